// ==== common/vec_csr_pkg.sv ====
package vec_csr_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int unsigned xlen    = 32;   // scalar register width
    localparam int unsigned vlen    = 512;  // bits per vector register
    localparam int unsigned mul_w   = 4;    // lmul / emul value, up to 8
    localparam int unsigned ew_w    = 7;    // sew / eew value, up to 64
    localparam int unsigned vlmax_w = 10;   // vlmax value, up to 512

    //////////////////////////////////////////////////
    // instruction fields
    //////////////////////////////////////////////////

    typedef enum logic [6:0] {
        opc_system = 7'h73
    } opcode_e;

    typedef enum logic [2:0] {
        csrrw  = 3'b001,
        csrrs  = 3'b010,
        csrrc  = 3'b011,
        csrrwi = 3'b101,
        csrrsi = 3'b110,
        csrrci = 3'b111
    } csr_funct_e;

    typedef enum logic [11:0] {
        csr_vstart = 12'h008,
        csr_vl     = 12'hC20,
        csr_vtype  = 12'hC21
    } csr_addr_e;

    //////////////////////////////////////////////////
    // vtype encodings, 4..7 reserved
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        lmul_1 = 3'd0,
        lmul_2 = 3'd1,
        lmul_4 = 3'd2,
        lmul_8 = 3'd3
    } vlmul_e;

    typedef enum logic [2:0] {
        ew8  = 3'd0,
        ew16 = 3'd1,
        ew32 = 3'd2,
        ew64 = 3'd3
    } vsew_e;

    // log2 of lmul, reserved falls back to lmul 1
    function automatic logic [2:0] lmul_log2(vlmul_e enc);
        case (enc)
            lmul_2:  return 3'd1;
            lmul_4:  return 3'd2;
            lmul_8:  return 3'd3;
            default: return 3'd0;
        endcase
    endfunction

    // log2 of sew, reserved falls back to 32
    function automatic logic [2:0] sew_log2(vsew_e enc);
        case (enc)
            ew8:     return 3'd3;
            ew16:    return 3'd4;
            ew64:    return 3'd6;
            default: return 3'd5;
        endcase
    endfunction

endpackage

// ==== vtype/vtype_config_reg.sv ====
`timescale 1ns/100ps

module vtype_config_reg
    import vec_csr_pkg::*;
(
    input  logic             clk,
    input  logic             n_rst,
    input  logic             csrwr_en,
    input  logic [xlen-1:0]  scalar1,
    input  logic [xlen-1:0]  scalar2,
    output vlmul_e           vtype_vlmul,
    output vsew_e            vtype_vsew,
    output logic             vtype_vta,
    output logic             vtype_vma,
    output logic             vtype_ill,
    output logic [xlen-1:0]  vl_q,
    output logic             csr_done
);

    logic csrwr_en_d;   // csrwr_en one cycle late
    logic cfg_wr;

    // one write per low-to-high transition of csrwr_en
    assign cfg_wr = csrwr_en & ~csrwr_en_d;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            csrwr_en_d <= 1'b0;
        end else begin
            csrwr_en_d <= csrwr_en;
        end
    end

    //////////////////////////////////////////////////
    // vtype and vl capture
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vtype_ill   <= 1'b1;    // no valid config until first vsetvl
            vtype_vma   <= 1'b0;
            vtype_vta   <= 1'b0;
            vtype_vsew  <= ew8;
            vtype_vlmul <= lmul_1;
            vl_q        <= '0;
            csr_done    <= 1'b0;
        end else begin
            csr_done <= cfg_wr;     // single-cycle pulse
            if (cfg_wr) begin
                vtype_ill   <= 1'b0;
                vtype_vma   <= scalar2[7];
                vtype_vta   <= scalar2[6];
                vtype_vsew  <= vsew_e'(scalar2[5:3]);
                vtype_vlmul <= vlmul_e'(scalar2[2:0]);
                vl_q        <= scalar1;
            end
        end
    end

endmodule

// ==== vtype/vtype_decoder.sv ====
`timescale 1ns/100ps

module vtype_decoder
    import vec_csr_pkg::*;
(
    input  vlmul_e              vtype_vlmul,
    input  vsew_e               vtype_vsew,
    output logic [mul_w-1:0]    vlmul,
    output logic [ew_w-1:0]     sew,
    output logic [vlmax_w-1:0]  vlmax
);

    logic [2:0]  lmul_sh;   // log2 lmul, 0..3
    logic [2:0]  sew_sh;    // log2 sew, 3..6
    logic [31:0] elems;     // elements per register at this sew

    //////////////////////////////////////////////////
    // encoding to numeric values
    //////////////////////////////////////////////////

    // reserved codes already mapped to lmul 1 / sew 32 by the helpers
    assign lmul_sh = lmul_log2(vtype_vlmul);
    assign sew_sh  = sew_log2(vtype_vsew);

    assign vlmul = mul_w'(1) << lmul_sh;
    assign sew   = ew_w'(1) << sew_sh;

    //////////////////////////////////////////////////
    // vlmax = vlen / sew * lmul
    //////////////////////////////////////////////////

    // vlen and sew are powers of two, so both steps are plain shifts
    assign elems = vlen >> sew_sh;

    // widest case is 512 / 8 * 8, still inside vlmax_w
    assign vlmax = vlmax_w'(elems << lmul_sh);

endmodule

// ==== design/mem_elem_decoder.sv ====
`timescale 1ns/100ps

module mem_elem_decoder
    import vec_csr_pkg::*;
(
    input  logic                mew,
    input  logic [2:0]          width,
    input  vlmul_e              vtype_vlmul,
    input  vsew_e               vtype_vsew,
    output logic [ew_w-1:0]     eew,
    output logic [mul_w-1:0]    emul,
    output logic [vlmax_w-1:0]  e_vlmax
);

    logic [2:0]  eew_sh;    // log2 eew
    logic [2:0]  lmul_sh;
    logic [2:0]  sew_sh;
    logic [3:0]  ratio_sum; // log2(eew * lmul)
    logic [1:0]  emul_sh;   // log2 emul, 0..3

    //////////////////////////////////////////////////
    // memory element width
    //////////////////////////////////////////////////

    always_comb begin
        case ({mew, width})
            4'b0000: eew_sh = 3'd3;     // 8
            4'b0101: eew_sh = 3'd4;     // 16
            4'b0110: eew_sh = 3'd5;     // 32
            4'b0111: eew_sh = 3'd6;     // 64
            default: eew_sh = 3'd5;
        endcase
    end

    assign eew = ew_w'(1) << eew_sh;

    //////////////////////////////////////////////////
    // emul = eew * lmul / sew
    //////////////////////////////////////////////////

    assign lmul_sh   = lmul_log2(vtype_vlmul);
    assign sew_sh    = sew_log2(vtype_vsew);
    assign ratio_sum = {1'b0, eew_sh} + {1'b0, lmul_sh};

    // fractional or above 8 collapses to emul 1
    always_comb begin
        if (ratio_sum >= {1'b0, sew_sh} && ratio_sum <= {1'b0, sew_sh} + 4'd3) begin
            emul_sh = 2'(ratio_sum - {1'b0, sew_sh});
        end else begin
            emul_sh = 2'd0;
        end
    end

    assign emul = mul_w'(1) << emul_sh;

    // effective vlmax, peaks at 64 * 8
    assign e_vlmax = vlmax_w'((vlen >> eew_sh) << emul_sh);

endmodule

// ==== design/csr_access_unit.sv ====
`timescale 1ns/100ps

module csr_access_unit
    import vec_csr_pkg::*;
(
    input  logic             clk,
    input  logic             n_rst,
    input  logic             csr_en,
    input  logic [xlen-1:0]  inst,
    input  logic [xlen-1:0]  scalar1,
    input  vlmul_e           vtype_vlmul,
    input  vsew_e            vtype_vsew,
    input  logic             vtype_vta,
    input  logic             vtype_vma,
    input  logic             vtype_ill,
    input  logic [xlen-1:0]  vl_q,
    output logic [xlen-1:0]  csr_out,
    output logic             csr_illegal,
    output logic [xlen-1:0]  start_element
);

    opcode_e         opcode;
    csr_funct_e      funct3;
    logic [4:0]      rs1_field;
    csr_addr_e       csr_addr;

    logic            funct_ok;      // one of the six csr forms
    logic            read_only_ok;  // set/clear with rs1 = x0
    logic [xlen-1:0] vtype_word;
    logic [xlen-1:0] vstart_q;
    logic [xlen-1:0] vstart_d;
    logic            vstart_wr;

    //////////////////////////////////////////////////
    // instruction fields
    //////////////////////////////////////////////////

    assign opcode    = opcode_e'(inst[6:0]);
    assign funct3    = csr_funct_e'(inst[14:12]);
    assign rs1_field = inst[19:15];
    assign csr_addr  = csr_addr_e'(inst[31:20]);

    assign funct_ok = (funct3 == csrrw)  || (funct3 == csrrs)  || (funct3 == csrrc) ||
                      (funct3 == csrrwi) || (funct3 == csrrsi) || (funct3 == csrrci);

    // vl and vtype only readable through forms that leave the csr untouched
    assign read_only_ok = (funct3 != csrrw) && (funct3 != csrrwi) && (rs1_field == 5'd0);

    // ill | zeros | vma vta vsew vlmul
    assign vtype_word = {vtype_ill, {(xlen-9){1'b0}}, vtype_vma, vtype_vta,
                         vtype_vsew, vtype_vlmul};

    //////////////////////////////////////////////////
    // decode and read mux
    //////////////////////////////////////////////////

    always_comb begin
        csr_out     = '0;
        csr_illegal = 1'b0;
        vstart_wr   = 1'b0;
        vstart_d    = vstart_q;

        if (csr_en) begin
            if (opcode != opc_system || !funct_ok) begin
                csr_illegal = 1'b1;
            end else begin
                case (csr_addr)
                    csr_vstart: begin
                        csr_out   = vstart_q;   // old value back to rd
                        vstart_wr = 1'b1;
                        case (funct3)
                            csrrs, csrrsi: vstart_d = vstart_q | scalar1;
                            csrrc, csrrci: vstart_d = vstart_q & ~scalar1;
                            default:       vstart_d = scalar1;
                        endcase
                    end
                    csr_vl: begin
                        if (read_only_ok) csr_out = vl_q;
                        else csr_illegal = 1'b1;
                    end
                    csr_vtype: begin
                        if (read_only_ok) csr_out = vtype_word;
                        else csr_illegal = 1'b1;
                    end
                    default: csr_illegal = 1'b1;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // vstart
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vstart_q <= '0;
        end else if (vstart_wr) begin   // legal access only
            vstart_q <= vstart_d;
        end
    end

    assign start_element = vstart_q;

endmodule

// ==== design/vec_csr_regfile.sv ====
`timescale 1ns/100ps

module vec_csr_regfile
    import vec_csr_pkg::*;
(
    input  logic                clk,
    input  logic                n_rst,
    // scalar core side
    input  logic [xlen-1:0]     inst,
    input  logic                csr_en,
    input  logic [xlen-1:0]     scalar1,    // avl / vstart operand
    input  logic [xlen-1:0]     scalar2,    // new vtype
    input  logic                mew,
    input  logic [2:0]          width,
    input  logic                csrwr_en,
    output logic [xlen-1:0]     csr_out,
    output logic                csr_illegal,
    // decoded configuration
    output logic [mul_w-1:0]    vlmul,
    output logic [mul_w-1:0]    emul,
    output logic [ew_w-1:0]     sew,
    output logic [ew_w-1:0]     eew,
    output logic [vlmax_w-1:0]  vlmax,
    output logic [vlmax_w-1:0]  e_vlmax,
    output logic                tail_agnostic,
    output logic                mask_agnostic,
    output logic [xlen-1:0]     vec_length,
    output logic [xlen-1:0]     start_element,
    output logic                csr_done
);

    vlmul_e vtype_vlmul;
    vsew_e  vtype_vsew;
    logic   vtype_ill;

    // vta, vma and vl go straight out and are shared with the access unit
    vtype_config_reg u_config (
        .clk         (clk),
        .n_rst       (n_rst),
        .csrwr_en    (csrwr_en),
        .scalar1     (scalar1),
        .scalar2     (scalar2),
        .vtype_vlmul (vtype_vlmul),
        .vtype_vsew  (vtype_vsew),
        .vtype_vta   (tail_agnostic),
        .vtype_vma   (mask_agnostic),
        .vtype_ill   (vtype_ill),
        .vl_q        (vec_length),
        .csr_done    (csr_done)
    );

    vtype_decoder u_vtype_dec (
        .vtype_vlmul (vtype_vlmul),
        .vtype_vsew  (vtype_vsew),
        .vlmul       (vlmul),
        .sew         (sew),
        .vlmax       (vlmax)
    );

    mem_elem_decoder u_mem_dec (
        .mew         (mew),
        .width       (width),
        .vtype_vlmul (vtype_vlmul),
        .vtype_vsew  (vtype_vsew),
        .eew         (eew),
        .emul        (emul),
        .e_vlmax     (e_vlmax)
    );

    csr_access_unit u_csr (
        .clk           (clk),
        .n_rst         (n_rst),
        .csr_en        (csr_en),
        .inst          (inst),
        .scalar1       (scalar1),
        .vtype_vlmul   (vtype_vlmul),
        .vtype_vsew    (vtype_vsew),
        .vtype_vta     (tail_agnostic),
        .vtype_vma     (mask_agnostic),
        .vtype_ill     (vtype_ill),
        .vl_q          (vec_length),
        .csr_out       (csr_out),
        .csr_illegal   (csr_illegal),
        .start_element (start_element)
    );

endmodule

// ==== bench/vec_csr_regfile_checker.sv ====
`timescale 1ns/100ps

module vec_csr_regfile_checker
    import vec_csr_pkg::*;
(
    input logic              clk,
    input logic              n_rst,
    input logic              csrwr_en,
    input logic              csr_done,
    input logic [mul_w-1:0]  vlmul,
    input logic [mul_w-1:0]  emul,
    input logic [ew_w-1:0]   sew,
    input logic [ew_w-1:0]   eew
);

    // done is a one-cycle pulse
    done_single_cycle: assert property (@(posedge clk) disable iff (!n_rst)
        csr_done |=> !csr_done)
        else $error("csr_done high in two consecutive cycles");

    // capture edge saw csrwr_en high after a low cycle
    done_after_rise: assert property (@(posedge clk) disable iff (!n_rst)
        csr_done |-> $past(csrwr_en) && !$past(csrwr_en, 2))
        else $error("csr_done without a rising csrwr_en");

    vlmul_range: assert property (@(posedge clk) disable iff (!n_rst)
        vlmul inside {4'd1, 4'd2, 4'd4, 4'd8})
        else $error("vlmul outside 1, 2, 4, 8");

    // emul above 1 must match eew * lmul / sew
    emul_range: assert property (@(posedge clk) disable iff (!n_rst)
        emul inside {4'd1, 4'd2, 4'd4, 4'd8} &&
        (emul == 4'd1 || int'(emul) * int'(sew) == int'(eew) * int'(vlmul)))
        else $error("emul outside 1, 2, 4, 8 or not equal to eew * lmul / sew");

endmodule

bind vec_csr_regfile vec_csr_regfile_checker u_checker (
    .clk      (clk),
    .n_rst    (n_rst),
    .csrwr_en (csrwr_en),
    .csr_done (csr_done),
    .vlmul    (vlmul),
    .emul     (emul),
    .sew      (sew),
    .eew      (eew)
);

// ==== bench/vec_csr_regfile_tb.sv ====
`timescale 1ns/100ps

module vec_csr_regfile_tb
    import vec_csr_pkg::*;
();

    localparam int max_cycles = 2000;

    logic                clk = 1'b0;
    logic                n_rst;
    logic [xlen-1:0]     inst;
    logic                csr_en;
    logic [xlen-1:0]     scalar1;
    logic [xlen-1:0]     scalar2;
    logic                mew;
    logic [2:0]          width;
    logic                csrwr_en;
    logic [xlen-1:0]     csr_out;
    logic                csr_illegal;
    logic [mul_w-1:0]    vlmul;
    logic [mul_w-1:0]    emul;
    logic [ew_w-1:0]     sew;
    logic [ew_w-1:0]     eew;
    logic [vlmax_w-1:0]  vlmax;
    logic [vlmax_w-1:0]  e_vlmax;
    logic                tail_agnostic;
    logic                mask_agnostic;
    logic [xlen-1:0]     vec_length;
    logic [xlen-1:0]     start_element;
    logic                csr_done;

    logic [31:0]         rng_state = 32'hd4555516;
    logic [xlen-1:0]     vstart_model;  // expected vstart
    logic [xlen-1:0]     vl_model;      // expected vl
    int                  cycle_count = 0;

    vec_csr_regfile uut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: tests did not finish within %0d cycles", max_cycles);
            $display("SIMULATION FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    //////////////////////////////////////////////////
    // helpers and reference rules
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // SYSTEM opcode with rd = x5
    function automatic logic [31:0] csr_inst(logic [11:0] addr, logic [4:0] rs1, logic [2:0] f3);
        return {addr, rs1, f3, 5'd5, 7'h73};
    endfunction

    function automatic int lmul_of(logic [2:0] enc);
        return (enc < 3'd4) ? (1 << enc) : 1;     // reserved -> 1
    endfunction

    function automatic int sew_of(logic [2:0] enc);
        return (enc < 3'd4) ? (8 << enc) : 32;    // reserved -> 32
    endfunction

    function automatic int eew_of(logic [3:0] mw);
        case (mw)
            4'b0000: return 8;
            4'b0101: return 16;
            4'b0110: return 32;
            4'b0111: return 64;
            default: return 32;
        endcase
    endfunction

    function automatic int emul_of(int e, int l, int s);
        int prod;
        prod = e * l;
        if (prod % s == 0 && prod / s >= 1 && prod / s <= 8) return prod / s;
        return 1;   // fractional or too large
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // instruction held across one edge with outputs sampled before it
    task automatic issue_csr(input logic [31:0] instr, input logic [31:0] operand,
                             output logic [31:0] rdata, output logic illegal);
        @(negedge clk);
        inst    = instr;
        scalar1 = operand;
        csr_en  = 1'b1;
        #10;
        rdata   = csr_out;
        illegal = csr_illegal;
        @(negedge clk);
        csr_en  = 1'b0;
        inst    = '0;
    endtask

    task automatic write_config(input logic [31:0] avl, input logic [31:0] vtype);
        @(negedge clk);
        scalar1  = avl;
        scalar2  = vtype;
        csrwr_en = 1'b1;
        @(negedge clk);
        check_value("csr_done", 32'(csr_done), 32'd1);
        csrwr_en = 1'b0;
        @(negedge clk);
        check_value("csr_done", 32'(csr_done), 32'd0);
        vl_model = avl;
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic reset_values();
        logic [31:0] rdata;
        logic        illegal;
        check_value("csr_done", 32'(csr_done), 32'd0);
        check_value("vec_length", vec_length, 32'd0);
        check_value("start_element", start_element, 32'd0);
        issue_csr(csr_inst(csr_vtype, 5'd0, csrrs), 32'd0, rdata, illegal);
        check_value("csr_out", rdata, 32'h8000_0000);   // only ill set
        check_value("csr_illegal", 32'(illegal), 32'd0);
    endtask

    task automatic config_writes();
        logic [31:0] avl;
        logic [31:0] vtype;
        logic [31:0] rdata;
        logic        illegal;
        for (int lm = 0; lm < 8; lm++) begin
            for (int sw = 0; sw < 8; sw++) begin
                avl        = next_random();
                vtype      = next_random();     // upper bits must be ignored
                vtype[5:0] = {3'(sw), 3'(lm)};
                write_config(avl, vtype);
                check_value("vlmul", 32'(vlmul), lmul_of(vtype[2:0]));
                check_value("sew", 32'(sew), sew_of(vtype[5:3]));
                check_value("vlmax", 32'(vlmax),
                            vlen / sew_of(vtype[5:3]) * lmul_of(vtype[2:0]));
                check_value("tail_agnostic", 32'(tail_agnostic), 32'(vtype[6]));
                check_value("mask_agnostic", 32'(mask_agnostic), 32'(vtype[7]));
                check_value("vec_length", vec_length, avl);
                issue_csr(csr_inst(csr_vtype, 5'd0, csrrs), 32'd0, rdata, illegal);
                check_value("csr_out", rdata, {24'd0, vtype[7:0]});
                check_value("csr_illegal", 32'(illegal), 32'd0);
                issue_csr(csr_inst(csr_vl, 5'd0, csrrc), 32'd0, rdata, illegal);
                check_value("csr_out", rdata, avl);
            end
        end
    endtask

    task automatic held_write();
        logic [31:0] first;
        first = next_random();
        @(negedge clk);
        scalar1  = 32'd77;
        scalar2  = first;
        csrwr_en = 1'b1;
        @(negedge clk);
        check_value("csr_done", 32'(csr_done), 32'd1);
        check_value("vec_length", vec_length, 32'd77);
        // strobe stays high so new operands must not land
        for (int i = 0; i < 4; i++) begin
            scalar1 = next_random();
            scalar2 = next_random();
            @(negedge clk);
            check_value("csr_done", 32'(csr_done), 32'd0);
            check_value("vec_length", vec_length, 32'd77);
            check_value("vlmul", 32'(vlmul), lmul_of(first[2:0]));
            check_value("tail_agnostic", 32'(tail_agnostic), 32'(first[6]));
            check_value("mask_agnostic", 32'(mask_agnostic), 32'(first[7]));
        end
        csrwr_en = 1'b0;
        vl_model = 32'd77;
    endtask

    task automatic mem_width_decode();
        int e;
        int l;
        int s;
        int m;
        for (int cfg = 0; cfg < 16; cfg++) begin
            write_config(next_random(), {24'd0, 2'b00, 3'(cfg >> 2), 3'(cfg & 3)});
            l = lmul_of(3'(cfg & 3));
            s = sew_of(3'(cfg >> 2));
            for (int mw = 0; mw < 16; mw++) begin
                @(negedge clk);
                {mew, width} = 4'(mw);
                #10;
                e = eew_of(4'(mw));
                m = emul_of(e, l, s);
                check_value("eew", 32'(eew), e);
                check_value("emul", 32'(emul), m);
                check_value("e_vlmax", 32'(e_vlmax), vlen / e * m);
            end
        end
    endtask

    task automatic vstart_access();
        logic [2:0]  forms [6];
        logic [2:0]  f3;
        logic [31:0] operand;
        logic [31:0] rdata;
        logic        illegal;
        forms = '{csrrw, csrrs, csrrc, csrrwi, csrrsi, csrrci};
        for (int i = 0; i < 48; i++) begin
            f3      = forms[3'(next_random() % 6)];
            operand = next_random();
            issue_csr(csr_inst(csr_vstart, operand[4:0], f3), operand, rdata, illegal);
            check_value("csr_out", rdata, vstart_model);    // old value
            check_value("csr_illegal", 32'(illegal), 32'd0);
            case (f3[1:0])
                2'b10:   vstart_model = vstart_model | operand;
                2'b11:   vstart_model = vstart_model & ~operand;
                default: vstart_model = operand;
            endcase
            check_value("start_element", start_element, vstart_model);
        end
    endtask

    task automatic expect_illegal(input string what, input logic [31:0] instr);
        logic [31:0] rdata;
        logic        illegal;
        issue_csr(instr, next_random(), rdata, illegal);
        check_value({"csr_illegal for ", what}, 32'(illegal), 32'd1);
        check_value({"csr_out for ", what}, rdata, 32'd0);
        check_value({"start_element for ", what}, start_element, vstart_model);
        check_value({"vec_length for ", what}, vec_length, vl_model);
    endtask

    task automatic illegal_accesses();
        expect_illegal("wrong opcode", csr_inst(csr_vstart, 5'd1, csrrw) ^ 32'h40);  // 0x33
        expect_illegal("funct3 000", csr_inst(csr_vstart, 5'd1, 3'b000));
        expect_illegal("funct3 100", csr_inst(csr_vstart, 5'd1, 3'b100));
        expect_illegal("unknown address", csr_inst(12'h009, 5'd0, csrrs));
        expect_illegal("csrrw to vl", csr_inst(csr_vl, 5'd0, csrrw));
        expect_illegal("csrrs vtype rs1", csr_inst(csr_vtype, 5'd3, csrrs));
        // instruction ignored while csr_en is low
        @(negedge clk);
        inst    = csr_inst(csr_vstart, 5'd0, csrrw);
        scalar1 = next_random();
        #10;
        check_value("csr_out", csr_out, 32'd0);
        check_value("csr_illegal", 32'(csr_illegal), 32'd0);
        @(negedge clk);
        check_value("start_element", start_element, vstart_model);
        inst = '0;
    endtask

    initial begin
        n_rst        = 1'b0;
        inst         = '0;
        csr_en       = 1'b0;
        scalar1      = '0;
        scalar2      = '0;
        mew          = 1'b0;
        width        = 3'd0;
        csrwr_en     = 1'b0;
        vstart_model = '0;
        vl_model     = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        reset_values();
        config_writes();
        held_write();
        mem_width_decode();
        vstart_access();
        illegal_accesses();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== vec_csr_regfile.f ====
common/vec_csr_pkg.sv
vtype/vtype_config_reg.sv
vtype/vtype_decoder.sv
design/mem_elem_decoder.sv
design/csr_access_unit.sv
design/vec_csr_regfile.sv
bench/vec_csr_regfile_checker.sv
bench/vec_csr_regfile_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module vec_csr_regfile_tb \
    -f vec_csr_regfile.f \
    -o vec_csr_regfile_sim

# the run result is judged from the printed output
output=$(./obj_dir/vec_csr_regfile_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
    exit 0
else
    echo "pass line not found in simulation output"
    exit 1
fi
